// ==== src/cpu_pkg.sv ====
package cpu_pkg;

    // ************************************************************************
    // basic types.
    // ************************************************************************

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // the three field layouts of one instruction word.
    typedef struct packed {
        logic [5:0] opcode;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fields_t;

    typedef struct packed {
        logic [5:0]  opcode;
        reg_addr_t   rs;
        reg_addr_t   rt;
        logic [15:0] imm;
    } i_fields_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] target;
    } j_fields_t;

    typedef union packed {
        r_fields_t r;
        i_fields_t i;
        j_fields_t j;
    } inst_t;

    // internal operation, shared by decode and execute.
    typedef enum logic [3:0] {
        OP_NOP,
        OP_ADDU,
        OP_SUBU,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_LUI,
        OP_BEQ,
        OP_BNE,
        OP_J
    } oper_t;

    // ************************************************************************
    // encodings and constants.
    // ************************************************************************

    localparam logic [5:0] OPC_SPECIAL = 6'h00;
    localparam logic [5:0] OPC_J       = 6'h02;
    localparam logic [5:0] OPC_BEQ     = 6'h04;
    localparam logic [5:0] OPC_BNE     = 6'h05;
    localparam logic [5:0] OPC_ADDIU   = 6'h09;
    localparam logic [5:0] OPC_ANDI    = 6'h0c;
    localparam logic [5:0] OPC_ORI     = 6'h0d;
    localparam logic [5:0] OPC_LUI     = 6'h0f;

    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    localparam word_t PC_RESET = 32'h0000_0000;

    // depth must be a power of two so the pointers wrap on their own.
    localparam int QUEUE_DEPTH = 4;
    localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);

endpackage

// ==== src/fetch_unit.sv ====
module fetch_unit (
    input  logic           clk,
    input  logic           reset_i,
    input  logic           branch_taken_i,
    input  cpu_pkg::word_t branch_target_i,
    output cpu_pkg::word_t imem_addr_o,
    input  cpu_pkg::word_t imem_data_i,
    output logic           push_valid_o,
    input  logic           push_ready_i,
    output cpu_pkg::word_t push_pc_o,
    output cpu_pkg::inst_t push_inst_o
);

    cpu_pkg::word_t pc;
    logic           fetch_en;

    assign imem_addr_o = pc;
    assign push_pc_o   = pc;
    assign push_inst_o = imem_data_i;

    // no push in a redirect cycle, the queue is being flushed.
    assign push_valid_o = fetch_en & ~branch_taken_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc       <= cpu_pkg::PC_RESET;
            fetch_en <= 1'b0;
        end else begin
            fetch_en <= 1'b1;
            if (branch_taken_i) begin
                pc <= branch_target_i;
            end else if (push_valid_o && push_ready_i) begin
                pc <= pc + 32'd4;
            end
        end
    end

endmodule

// ==== src/fetch_queue.sv ====
module fetch_queue (
    input  logic           clk,
    input  logic           reset_i,
    input  logic           flush_i,
    input  logic           push_valid_i,
    output logic           push_ready_o,
    input  cpu_pkg::word_t push_pc_i,
    input  cpu_pkg::inst_t push_inst_i,
    output logic           pop_valid_o,
    input  logic           pop_ready_i,
    output cpu_pkg::word_t pop_pc_o,
    output cpu_pkg::inst_t pop_inst_o
);

    cpu_pkg::word_t pc_mem   [cpu_pkg::QUEUE_DEPTH];
    cpu_pkg::inst_t inst_mem [cpu_pkg::QUEUE_DEPTH];

    logic [cpu_pkg::QUEUE_PTR_W-1:0] wr_ptr;
    logic [cpu_pkg::QUEUE_PTR_W-1:0] rd_ptr;
    logic [cpu_pkg::QUEUE_PTR_W:0]   count;
    logic                            do_push;
    logic                            do_pop;

    assign push_ready_o = (count != cpu_pkg::QUEUE_DEPTH);
    assign pop_valid_o  = (count != '0);
    assign pop_pc_o     = pc_mem[rd_ptr];
    assign pop_inst_o   = inst_mem[rd_ptr];

    assign do_push = push_valid_i & push_ready_o & ~flush_i;
    assign do_pop  = pop_valid_o & pop_ready_i & ~flush_i;

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + do_push - do_pop;
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            pc_mem[wr_ptr]   <= push_pc_i;
            inst_mem[wr_ptr] <= push_inst_i;
        end
    end

endmodule

// ==== src/reg_file.sv ====
module reg_file (
    input  logic               clk,
    input  cpu_pkg::reg_addr_t rs_addr_i,
    input  cpu_pkg::reg_addr_t rt_addr_i,
    output cpu_pkg::word_t     rs_data_o,
    output cpu_pkg::word_t     rt_data_o,
    input  logic               we_i,
    input  cpu_pkg::reg_addr_t waddr_i,
    input  cpu_pkg::word_t     wdata_i
);

    cpu_pkg::word_t regs [32];

    // register zero always reads as zero.
    assign rs_data_o = (rs_addr_i == '0) ? '0 : regs[rs_addr_i];
    assign rt_data_o = (rt_addr_i == '0) ? '0 : regs[rt_addr_i];

    always_ff @(posedge clk) begin
        if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

endmodule

// ==== src/decode_stage.sv ====
module decode_stage (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               pop_valid_i,
    output logic               pop_ready_o,
    input  cpu_pkg::word_t     pop_pc_i,
    input  cpu_pkg::inst_t     pop_inst_i,
    output cpu_pkg::reg_addr_t rs_addr_o,
    output cpu_pkg::reg_addr_t rt_addr_o,
    input  cpu_pkg::word_t     rs_data_i,
    input  cpu_pkg::word_t     rt_data_i,
    input  logic               ex_we_i,
    input  cpu_pkg::reg_addr_t ex_waddr_i,
    input  cpu_pkg::word_t     ex_wdata_i,
    input  logic               wb_we_i,
    input  cpu_pkg::reg_addr_t wb_waddr_i,
    input  cpu_pkg::word_t     wb_wdata_i,
    output logic               branch_taken_o,
    output cpu_pkg::word_t     branch_target_o,
    output logic               id_valid_o,
    output cpu_pkg::word_t     id_pc_o,
    output cpu_pkg::oper_t     id_oper_o,
    output cpu_pkg::word_t     id_op1_o,
    output cpu_pkg::word_t     id_op2_o,
    output logic               id_we_o,
    output cpu_pkg::reg_addr_t id_waddr_o
);

    cpu_pkg::oper_t     oper;
    cpu_pkg::reg_addr_t waddr;
    cpu_pkg::word_t     imm;
    cpu_pkg::word_t     op1;
    cpu_pkg::word_t     op2;
    cpu_pkg::word_t     pc_next;
    logic               rs_read;
    logic               rt_read;
    logic               we;
    logic               sign_ext;
    logic               ready_q;
    logic               take;

    // execute result wins over writeback, writeback over the register file.
    function automatic cpu_pkg::word_t fwd_operand(input cpu_pkg::reg_addr_t addr,
                                                   input cpu_pkg::word_t     rf_data);
        if (addr == '0) begin
            fwd_operand = '0;
        end else if (ex_we_i && ex_waddr_i == addr) begin
            fwd_operand = ex_wdata_i;
        end else if (wb_we_i && wb_waddr_i == addr) begin
            fwd_operand = wb_wdata_i;
        end else begin
            fwd_operand = rf_data;
        end
    endfunction

    assign pop_ready_o = ready_q;
    assign take        = pop_valid_i & pop_ready_o;
    assign rs_addr_o   = pop_inst_i.r.rs;
    assign rt_addr_o   = pop_inst_i.r.rt;

    // ************************************************************************
    // instruction decode.
    // ************************************************************************

    always_comb begin
        oper     = cpu_pkg::OP_NOP;
        rs_read  = 1'b0;
        rt_read  = 1'b0;
        sign_ext = 1'b1;
        waddr    = pop_inst_i.i.rt;
        case (pop_inst_i.r.opcode)
            cpu_pkg::OPC_SPECIAL: begin
                rs_read = 1'b1;
                rt_read = 1'b1;
                waddr   = pop_inst_i.r.rd;
                case (pop_inst_i.r.funct)
                    cpu_pkg::FN_ADDU: oper = cpu_pkg::OP_ADDU;
                    cpu_pkg::FN_SUBU: oper = cpu_pkg::OP_SUBU;
                    cpu_pkg::FN_AND:  oper = cpu_pkg::OP_AND;
                    cpu_pkg::FN_OR:   oper = cpu_pkg::OP_OR;
                    cpu_pkg::FN_XOR:  oper = cpu_pkg::OP_XOR;
                    cpu_pkg::FN_SLT:  oper = cpu_pkg::OP_SLT;
                    default:          oper = cpu_pkg::OP_NOP;
                endcase
            end
            cpu_pkg::OPC_ADDIU: begin
                oper    = cpu_pkg::OP_ADDU;
                rs_read = 1'b1;
            end
            cpu_pkg::OPC_ANDI: begin
                oper     = cpu_pkg::OP_AND;
                rs_read  = 1'b1;
                sign_ext = 1'b0;
            end
            cpu_pkg::OPC_ORI: begin
                oper     = cpu_pkg::OP_OR;
                rs_read  = 1'b1;
                sign_ext = 1'b0;
            end
            cpu_pkg::OPC_LUI: begin
                oper     = cpu_pkg::OP_LUI;
                sign_ext = 1'b0;
            end
            cpu_pkg::OPC_BEQ: begin
                oper    = cpu_pkg::OP_BEQ;
                rs_read = 1'b1;
                rt_read = 1'b1;
            end
            cpu_pkg::OPC_BNE: begin
                oper    = cpu_pkg::OP_BNE;
                rs_read = 1'b1;
                rt_read = 1'b1;
            end
            cpu_pkg::OPC_J: oper = cpu_pkg::OP_J;
            default:        oper = cpu_pkg::OP_NOP;
        endcase
    end

    // only ALU operations write a register.
    assign we = (oper != cpu_pkg::OP_NOP) && (oper != cpu_pkg::OP_BEQ) &&
                (oper != cpu_pkg::OP_BNE) && (oper != cpu_pkg::OP_J);

    assign imm = sign_ext ? {{16{pop_inst_i.i.imm[15]}}, pop_inst_i.i.imm}
                          : {16'h0000, pop_inst_i.i.imm};

    // an operand that is not read carries the immediate.
    always_comb begin
        op1 = rs_read ? fwd_operand(pop_inst_i.r.rs, rs_data_i) : imm;
        op2 = rt_read ? fwd_operand(pop_inst_i.r.rt, rt_data_i) : imm;
    end

    // ************************************************************************
    // branch resolution.
    // ************************************************************************

    assign pc_next = pop_pc_i + 32'd4;

    always_comb begin
        if (oper == cpu_pkg::OP_J) begin
            branch_target_o = {pc_next[31:28], pop_inst_i.j.target, 2'b00};
        end else begin
            branch_target_o = pc_next + {imm[29:0], 2'b00};
        end
    end

    assign branch_taken_o = take & ((oper == cpu_pkg::OP_BEQ && op1 == op2) ||
                                    (oper == cpu_pkg::OP_BNE && op1 != op2) ||
                                    (oper == cpu_pkg::OP_J));

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ready_q    <= 1'b0;
            id_valid_o <= 1'b0;
            id_we_o    <= 1'b0;
        end else begin
            ready_q    <= 1'b1;
            id_valid_o <= take;
            id_we_o    <= take & we & ~branch_taken_o;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            id_pc_o    <= pop_pc_i;
            id_oper_o  <= oper;
            id_op1_o   <= op1;
            id_op2_o   <= op2;
            id_waddr_o <= waddr;
        end
    end

endmodule

// ==== src/exec_stage.sv ====
module exec_stage (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               id_valid_i,
    input  cpu_pkg::word_t     id_pc_i,
    input  cpu_pkg::oper_t     id_oper_i,
    input  cpu_pkg::word_t     id_op1_i,
    input  cpu_pkg::word_t     id_op2_i,
    input  logic               id_we_i,
    input  cpu_pkg::reg_addr_t id_waddr_i,
    output logic               ex_we_o,
    output cpu_pkg::reg_addr_t ex_waddr_o,
    output cpu_pkg::word_t     ex_wdata_o,
    output logic               retire_valid_o,
    output cpu_pkg::word_t     retire_pc_o,
    output logic               retire_we_o,
    output cpu_pkg::reg_addr_t retire_waddr_o,
    output cpu_pkg::word_t     retire_wdata_o
);

    cpu_pkg::word_t alu_result;

    always_comb begin
        case (id_oper_i)
            cpu_pkg::OP_ADDU: alu_result = id_op1_i + id_op2_i;
            cpu_pkg::OP_SUBU: alu_result = id_op1_i - id_op2_i;
            cpu_pkg::OP_AND:  alu_result = id_op1_i & id_op2_i;
            cpu_pkg::OP_OR:   alu_result = id_op1_i | id_op2_i;
            cpu_pkg::OP_XOR:  alu_result = id_op1_i ^ id_op2_i;
            cpu_pkg::OP_SLT:  alu_result = {31'd0, $signed(id_op1_i) < $signed(id_op2_i)};
            cpu_pkg::OP_LUI:  alu_result = {id_op2_i[15:0], 16'h0000};
            default:          alu_result = '0;
        endcase
    end

    // forwarding bus from the execute stage.
    assign ex_we_o    = id_valid_i & id_we_i;
    assign ex_waddr_o = id_waddr_i;
    assign ex_wdata_o = alu_result;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            retire_valid_o <= 1'b0;
            retire_we_o    <= 1'b0;
        end else begin
            retire_valid_o <= id_valid_i;
            retire_we_o    <= ex_we_o;
        end
    end

    // a write to register zero retires as zero.
    always_ff @(posedge clk) begin
        retire_pc_o    <= id_pc_i;
        retire_waddr_o <= id_waddr_i;
        retire_wdata_o <= (id_waddr_i == '0) ? '0 : alu_result;
    end

endmodule

// ==== src/core_top.sv ====
module core_top (
    input  logic               clk,
    input  logic               reset_i,
    output cpu_pkg::word_t     imem_addr_o,
    input  cpu_pkg::word_t     imem_data_i,
    output logic               retire_valid_o,
    output cpu_pkg::word_t     retire_pc_o,
    output logic               retire_we_o,
    output cpu_pkg::reg_addr_t retire_waddr_o,
    output cpu_pkg::word_t     retire_wdata_o
);

    logic               push_valid;
    logic               push_ready;
    cpu_pkg::word_t     push_pc;
    cpu_pkg::inst_t     push_inst;
    logic               pop_valid;
    logic               pop_ready;
    cpu_pkg::word_t     pop_pc;
    cpu_pkg::inst_t     pop_inst;
    logic               branch_taken;
    cpu_pkg::word_t     branch_target;
    cpu_pkg::reg_addr_t rs_addr;
    cpu_pkg::reg_addr_t rt_addr;
    cpu_pkg::word_t     rs_data;
    cpu_pkg::word_t     rt_data;
    logic               ex_we;
    cpu_pkg::reg_addr_t ex_waddr;
    cpu_pkg::word_t     ex_wdata;
    logic               id_valid;
    cpu_pkg::word_t     id_pc;
    cpu_pkg::oper_t     id_oper;
    cpu_pkg::word_t     id_op1;
    cpu_pkg::word_t     id_op2;
    logic               id_we;
    cpu_pkg::reg_addr_t id_waddr;

    fetch_unit fetch_unit_inst (
        .clk             (clk),
        .reset_i         (reset_i),
        .branch_taken_i  (branch_taken),
        .branch_target_i (branch_target),
        .imem_addr_o     (imem_addr_o),
        .imem_data_i     (imem_data_i),
        .push_valid_o    (push_valid),
        .push_ready_i    (push_ready),
        .push_pc_o       (push_pc),
        .push_inst_o     (push_inst)
    );

    fetch_queue fetch_queue_inst (
        .clk          (clk),
        .reset_i      (reset_i),
        .flush_i      (branch_taken),
        .push_valid_i (push_valid),
        .push_ready_o (push_ready),
        .push_pc_i    (push_pc),
        .push_inst_i  (push_inst),
        .pop_valid_o  (pop_valid),
        .pop_ready_i  (pop_ready),
        .pop_pc_o     (pop_pc),
        .pop_inst_o   (pop_inst)
    );

    // the writeback register is both the retire port and the write port.
    decode_stage decode_stage_inst (
        .clk             (clk),
        .reset_i         (reset_i),
        .pop_valid_i     (pop_valid),
        .pop_ready_o     (pop_ready),
        .pop_pc_i        (pop_pc),
        .pop_inst_i      (pop_inst),
        .rs_addr_o       (rs_addr),
        .rt_addr_o       (rt_addr),
        .rs_data_i       (rs_data),
        .rt_data_i       (rt_data),
        .ex_we_i         (ex_we),
        .ex_waddr_i      (ex_waddr),
        .ex_wdata_i      (ex_wdata),
        .wb_we_i         (retire_we_o),
        .wb_waddr_i      (retire_waddr_o),
        .wb_wdata_i      (retire_wdata_o),
        .branch_taken_o  (branch_taken),
        .branch_target_o (branch_target),
        .id_valid_o      (id_valid),
        .id_pc_o         (id_pc),
        .id_oper_o       (id_oper),
        .id_op1_o        (id_op1),
        .id_op2_o        (id_op2),
        .id_we_o         (id_we),
        .id_waddr_o      (id_waddr)
    );

    reg_file reg_file_inst (
        .clk       (clk),
        .rs_addr_i (rs_addr),
        .rt_addr_i (rt_addr),
        .rs_data_o (rs_data),
        .rt_data_o (rt_data),
        .we_i      (retire_we_o),
        .waddr_i   (retire_waddr_o),
        .wdata_i   (retire_wdata_o)
    );

    exec_stage exec_stage_inst (
        .clk            (clk),
        .reset_i        (reset_i),
        .id_valid_i     (id_valid),
        .id_pc_i        (id_pc),
        .id_oper_i      (id_oper),
        .id_op1_i       (id_op1),
        .id_op2_i       (id_op2),
        .id_we_i        (id_we),
        .id_waddr_i     (id_waddr),
        .ex_we_o        (ex_we),
        .ex_waddr_o     (ex_waddr),
        .ex_wdata_o     (ex_wdata),
        .retire_valid_o (retire_valid_o),
        .retire_pc_o    (retire_pc_o),
        .retire_we_o    (retire_we_o),
        .retire_waddr_o (retire_waddr_o),
        .retire_wdata_o (retire_wdata_o)
    );

endmodule

// ==== bench/core_tb.sv ====
module core_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int PROG_LEN   = 64;
    localparam int MEM_WORDS  = 256;
    localparam int KIND_RTYPE = 0;
    localparam int KIND_IMM   = 1;
    localparam int KIND_FWD   = 2;
    localparam int KIND_CTRL  = 3;
    localparam int KIND_REDIR = 4;

    logic                clk;
    logic                reset_i;
    cpu_pkg::word_t      imem_addr_o;
    cpu_pkg::word_t      imem_data_i;
    logic                retire_valid_o;
    cpu_pkg::word_t      retire_pc_o;
    logic                retire_we_o;
    cpu_pkg::reg_addr_t  retire_waddr_o;
    cpu_pkg::word_t      retire_wdata_o;

    cpu_pkg::word_t      imem [MEM_WORDS];
    cpu_pkg::word_t      exp_pc [MEM_WORDS];
    logic                exp_we [MEM_WORDS];
    cpu_pkg::reg_addr_t  exp_waddr [MEM_WORDS];
    cpu_pkg::word_t      exp_wdata [MEM_WORDS];
    int                  n_exp;
    int                  errors = 0;
    int                  pass_cnt = 0;
    int                  fail_cnt = 0;
    int                  cycle_count = 0;
    int                  cycle_limit = 200;

    // combinational instruction memory, word addressed.
    assign imem_data_i = imem[imem_addr_o[9:2]];

    core_top core_top_inst (
        .clk            (clk),
        .reset_i        (reset_i),
        .imem_addr_o    (imem_addr_o),
        .imem_data_i    (imem_data_i),
        .retire_valid_o (retire_valid_o),
        .retire_pc_o    (retire_pc_o),
        .retire_we_o    (retire_we_o),
        .retire_waddr_o (retire_waddr_o),
        .retire_wdata_o (retire_wdata_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin : watchdog
        while (cycle_count <= cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles, the core stopped retiring", cycle_count);
        $display("TESTS FAILED");
        $finish;
    end

    task automatic check(input string name, input cpu_pkg::word_t expected,
                         input cpu_pkg::word_t actual);
        if (expected !== actual) begin
            $display("ERR %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    // ************************************************************************
    // instruction encoding and random program generation.
    // ************************************************************************

    function automatic cpu_pkg::word_t rtype_word(input logic [5:0] funct,
                                                  input cpu_pkg::reg_addr_t rs,
                                                  input cpu_pkg::reg_addr_t rt,
                                                  input cpu_pkg::reg_addr_t rd);
        cpu_pkg::inst_t w;
        w.r.opcode = cpu_pkg::OPC_SPECIAL;
        w.r.rs     = rs;
        w.r.rt     = rt;
        w.r.rd     = rd;
        w.r.shamt  = 5'd0;
        w.r.funct  = funct;
        return w;
    endfunction

    function automatic cpu_pkg::word_t itype_word(input logic [5:0] opcode,
                                                  input cpu_pkg::reg_addr_t rs,
                                                  input cpu_pkg::reg_addr_t rt,
                                                  input logic [15:0] imm);
        cpu_pkg::inst_t w;
        w.i.opcode = opcode;
        w.i.rs     = rs;
        w.i.rt     = rt;
        w.i.imm    = imm;
        return w;
    endfunction

    function automatic cpu_pkg::word_t jump_word(input int target_idx);
        cpu_pkg::inst_t w;
        w.j.opcode = cpu_pkg::OPC_J;
        w.j.target = 26'(target_idx);
        return w;
    endfunction

    // a small register pool keeps dependencies close together.
    function automatic cpu_pkg::reg_addr_t pool_reg();
        return 5'($urandom_range(7));
    endfunction

    function automatic cpu_pkg::word_t random_rtype(input cpu_pkg::reg_addr_t rs,
                                                    input cpu_pkg::reg_addr_t rt,
                                                    input cpu_pkg::reg_addr_t rd);
        logic [5:0] funct;
        case ($urandom_range(5))
            0:       funct = cpu_pkg::FN_ADDU;
            1:       funct = cpu_pkg::FN_SUBU;
            2:       funct = cpu_pkg::FN_AND;
            3:       funct = cpu_pkg::FN_OR;
            4:       funct = cpu_pkg::FN_XOR;
            default: funct = cpu_pkg::FN_SLT;
        endcase
        return rtype_word(funct, rs, rt, rd);
    endfunction

    function automatic cpu_pkg::word_t random_itype(input cpu_pkg::reg_addr_t rs,
                                                    input cpu_pkg::reg_addr_t rd);
        logic [15:0] imm;
        imm = 16'($urandom);
        case ($urandom_range(3))
            0:       return itype_word(cpu_pkg::OPC_ADDIU, rs, rd, imm);
            1:       return itype_word(cpu_pkg::OPC_ANDI, rs, rd, imm);
            2:       return itype_word(cpu_pkg::OPC_ORI, rs, rd, imm);
            default: return itype_word(cpu_pkg::OPC_LUI, 5'd0, rd, imm);
        endcase
    endfunction

    function automatic cpu_pkg::word_t random_alu(input cpu_pkg::reg_addr_t rd);
        if ($urandom_range(1) == 0) begin
            return random_rtype(pool_reg(), pool_reg(), rd);
        end
        return random_itype(pool_reg(), rd);
    endfunction

    // targets always lie ahead of k and inside the program.
    function automatic cpu_pkg::word_t random_branch(input int k, input logic always_taken);
        int                 off;
        int                 room;
        cpu_pkg::reg_addr_t rs;
        cpu_pkg::reg_addr_t rt;
        room = PROG_LEN - 2 - k;
        off  = $urandom_range((room < 3) ? room : 3);
        rs   = pool_reg();
        rt   = (always_taken || $urandom_range(2) == 0) ? rs : pool_reg();
        case ($urandom_range(2))
            0: return itype_word(cpu_pkg::OPC_BEQ, rs, rt, 16'(off));
            1: return itype_word(always_taken ? cpu_pkg::OPC_BEQ : cpu_pkg::OPC_BNE,
                                 rs, rt, 16'(off));
            default: return jump_word(k + 1 + off);
        endcase
    endfunction

    task automatic gen_program(input int kind);
        cpu_pkg::reg_addr_t rd;
        cpu_pkg::reg_addr_t last_rd;
        cpu_pkg::reg_addr_t prev_rd;
        int                 run_left;
        last_rd  = 5'd1;
        prev_rd  = 5'd2;
        run_left = 0;
        // words past the program must never retire.
        for (int k = 0; k < MEM_WORDS; k++) begin
            imem[k] = itype_word(cpu_pkg::OPC_ADDIU, 5'd0, 5'd9, 16'(k));
        end
        for (int k = 0; k < 7; k++) begin
            imem[k] = itype_word(cpu_pkg::OPC_ADDIU, 5'd0, 5'(k + 1), 16'($urandom));
        end
        for (int k = 7; k < PROG_LEN - 1; k++) begin
            rd = pool_reg();
            case (kind)
                KIND_RTYPE: imem[k] = random_rtype(pool_reg(), pool_reg(), rd);
                KIND_IMM:   imem[k] = random_itype(pool_reg(), rd);
                KIND_FWD: begin
                    rd = 5'($urandom_range(7, 1));
                    if ($urandom_range(1) == 0) begin
                        imem[k] = random_rtype(last_rd, prev_rd, rd);
                    end else begin
                        imem[k] = random_itype(last_rd, rd);
                    end
                    prev_rd = last_rd;
                    last_rd = rd;
                end
                KIND_CTRL: begin
                    if ($urandom_range(3) == 0) begin
                        imem[k] = random_branch(k, 1'b0);
                    end else begin
                        imem[k] = random_alu(rd);
                    end
                end
                default: begin
                    if (run_left == 0 && $urandom_range(2) == 0) begin
                        run_left = $urandom_range(4, 2);
                    end
                    if (run_left > 0) begin
                        imem[k] = random_branch(k, 1'b1);
                        run_left--;
                    end else begin
                        imem[k] = random_alu(rd);
                    end
                end
            endcase
        end
        imem[PROG_LEN - 1] = jump_word(PROG_LEN - 1);
    endtask

    // ************************************************************************
    // reference model and test sequence.
    // ************************************************************************

    task automatic run_model();
        cpu_pkg::word_t     regs [32];
        cpu_pkg::inst_t     w;
        cpu_pkg::word_t     pc;
        cpu_pkg::word_t     next_pc;
        cpu_pkg::word_t     a;
        cpu_pkg::word_t     b;
        cpu_pkg::word_t     simm;
        cpu_pkg::word_t     zimm;
        cpu_pkg::word_t     wdata;
        cpu_pkg::reg_addr_t waddr;
        logic               we;
        logic               done;
        foreach (regs[r]) begin
            regs[r] = '0;
        end
        pc    = cpu_pkg::PC_RESET;
        n_exp = 0;
        done  = 1'b0;
        while (!done && n_exp < MEM_WORDS) begin
            w       = imem[pc[9:2]];
            a       = regs[w.r.rs];
            b       = regs[w.r.rt];
            simm    = {{16{w.i.imm[15]}}, w.i.imm};
            zimm    = {16'h0000, w.i.imm};
            next_pc = pc + 32'd4;
            we      = 1'b1;
            waddr   = w.i.rt;
            wdata   = '0;
            case (w.r.opcode)
                cpu_pkg::OPC_SPECIAL: begin
                    waddr = w.r.rd;
                    case (w.r.funct)
                        cpu_pkg::FN_ADDU: wdata = a + b;
                        cpu_pkg::FN_SUBU: wdata = a - b;
                        cpu_pkg::FN_AND:  wdata = a & b;
                        cpu_pkg::FN_OR:   wdata = a | b;
                        cpu_pkg::FN_XOR:  wdata = a ^ b;
                        cpu_pkg::FN_SLT:  wdata = {31'd0, $signed(a) < $signed(b)};
                        default:          we = 1'b0;
                    endcase
                end
                cpu_pkg::OPC_ADDIU: wdata = a + simm;
                cpu_pkg::OPC_ANDI:  wdata = a & zimm;
                cpu_pkg::OPC_ORI:   wdata = a | zimm;
                cpu_pkg::OPC_LUI:   wdata = {w.i.imm, 16'h0000};
                cpu_pkg::OPC_BEQ: begin
                    we = 1'b0;
                    if (a == b) begin
                        next_pc = pc + 32'd4 + (simm << 2);
                    end
                end
                cpu_pkg::OPC_BNE: begin
                    we = 1'b0;
                    if (a != b) begin
                        next_pc = pc + 32'd4 + (simm << 2);
                    end
                end
                cpu_pkg::OPC_J: begin
                    we      = 1'b0;
                    next_pc = {next_pc[31:28], w.j.target, 2'b00};
                    done    = (next_pc == pc);
                end
                default: we = 1'b0;
            endcase
            // register zero keeps its value, so its writes retire as zero.
            if (we && waddr == 5'd0) begin
                wdata = '0;
            end else if (we) begin
                regs[waddr] = wdata;
            end
            exp_pc[n_exp]    = pc;
            exp_we[n_exp]    = we;
            exp_waddr[n_exp] = waddr;
            exp_wdata[n_exp] = wdata;
            n_exp++;
            pc = next_pc;
        end
    endtask

    task automatic run_test(input string name, input int kind);
        int    idx;
        int    errs_before;
        string label;
        errs_before = errors;
        gen_program(kind);
        run_model();
        cycle_limit += 4 * n_exp;
        @(posedge clk);
        reset_i <= 1'b1;
        // three reset cycles, then two more with no retirement expected.
        for (int i = 0; i < 5; i++) begin
            @(posedge clk);
            if (i == 2) begin
                reset_i <= 1'b0;
            end
            @(negedge clk);
            check($sformatf("%s retire_valid in reset window %0d", name, i), 32'd0,
                  retire_valid_o);
        end
        idx = 0;
        while (idx < n_exp) begin
            @(negedge clk);
            if (retire_valid_o) begin
                label = $sformatf("%s retire %0d", name, idx);
                check($sformatf("%s pc", label), exp_pc[idx], retire_pc_o);
                check($sformatf("%s we", label), exp_we[idx], retire_we_o);
                if (exp_we[idx]) begin
                    check($sformatf("%s waddr", label), exp_waddr[idx], retire_waddr_o);
                    check($sformatf("%s wdata", label), exp_wdata[idx], retire_wdata_o);
                end
                idx++;
            end
        end
        if (errors == errs_before) begin
            pass_cnt++;
            $display("test %s: pass, %0d instructions retired", name, n_exp);
        end else begin
            fail_cnt++;
            $display("test %s: fail, %0d mismatches", name, errors - errs_before);
        end
    endtask

    initial begin
        void'($urandom(45));
        reset_i = 1'b1;
        run_test("reset", KIND_RTYPE);
        run_test("rtype", KIND_RTYPE);
        run_test("immediate", KIND_IMM);
        run_test("forwarding", KIND_FWD);
        run_test("control", KIND_CTRL);
        run_test("control_2", KIND_CTRL);
        run_test("redirect", KIND_REDIR);
        run_test("redirect_2", KIND_REDIR);
        $display("summary: %0d passed, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== project.f ====
src/cpu_pkg.sv
src/fetch_unit.sv
src/fetch_queue.sv
src/reg_file.sv
src/decode_stage.sv
src/exec_stage.sv
src/core_top.sv
bench/core_tb.sv
